//--- design/video_pkg.sv
`default_nettype none

package video_pkg;

  // ==========================================================
  // raw camera bus
  // ==========================================================

  // one byte off the parallel camera data lines
  typedef logic [7:0] cam_byte_t;

  // camera bus after the synchronizers
  // pixel clock travels separately as a rise strobe
  typedef struct packed {
    cam_byte_t data;
    logic      hsync;
    logic      vsync;
  } cam_bus_t;

  // first camera byte of a pixel lands in the upper half
  typedef enum logic {
    high_byte = 1'b0,
    low_byte  = 1'b1
  } byte_phase_e;

  // ==========================================================
  // reconstructed pixels
  // ==========================================================

  // rgb565, red on top and blue in the low bits
  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } rgb565_t;

  // position of a pixel inside the frame
  typedef logic [10:0] hcount_t;
  typedef logic [9:0]  vcount_t;

  // one pixel with its position, qualified by a separate valid strobe
  typedef struct packed {
    rgb565_t pixel;
    hcount_t hcount;
    vcount_t vcount;
  } pixel_beat_t;

  // pixel beat plus its green-screen key bit
  typedef struct packed {
    pixel_beat_t beat;
    logic        mask;
  } keyed_beat_t;

endpackage

`default_nettype wire

//--- design/stream_pkg.sv
`default_nettype none

package stream_pkg;

  // ==========================================================
  // chunk stream toward the memory side
  // ==========================================================

  // pixels packed into one 128-bit chunk
  localparam int PIXELS_PER_CHUNK = 8;

  // rgb565 pixel width inside a chunk
  localparam int PIXEL_BITS = 16;

  // slot 0 sits in the lowest 16 bits
  typedef logic [PIXELS_PER_CHUNK-1:0][PIXEL_BITS-1:0] chunk_pixels_t;

  // bit i keys pixel i of the chunk
  typedef logic [PIXELS_PER_CHUNK-1:0] chunk_mask_t;

  // one beat of the valid/ready chunk stream
  // last marks the chunk holding the final pixel of a frame
  typedef struct packed {
    chunk_pixels_t pixels;
    chunk_mask_t   mask;
    logic          last;
  } chunk_t;

endpackage

`default_nettype wire

//--- design/camera_input_sync.sv
`timescale 1ns/1ps
`default_nettype none

module camera_input_sync (
  input  wire                  clk_camera,
  input  wire                  recent_reset,
  input  wire video_pkg::cam_byte_t camera_d_i,
  input  wire                  cam_pclk_i,
  input  wire                  cam_hsync_i,
  input  wire                  cam_vsync_i,
  output video_pkg::cam_bus_t  bus_o,
  output logic                 pclk_rise_o
);

  // data lines through two stages
  video_pkg::cam_byte_t data_meta;
  video_pkg::cam_byte_t data_sync;

  // control lines packed as {pclk, hsync, vsync}
  logic [2:0] ctrl_meta;
  logic [2:0] ctrl_sync;

  // extra pclk sample for edge detection
  logic pclk_prev;

  always_ff @(posedge clk_camera) begin
    data_meta <= camera_d_i;
    data_sync <= data_meta;
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      ctrl_meta   <= '0;
      ctrl_sync   <= '0;
      pclk_prev   <= 1'b0;
      pclk_rise_o <= 1'b0;
    end else begin
      ctrl_meta   <= {cam_pclk_i, cam_hsync_i, cam_vsync_i};
      ctrl_sync   <= ctrl_meta;
      pclk_prev   <= ctrl_sync[2];
      // one-cycle strobe landing the cycle after sync is first seen high
      pclk_rise_o <= ctrl_sync[2] & ~pclk_prev;
    end
  end

  // bus appears two cycles after the pins
  assign bus_o = '{data: data_sync, hsync: ctrl_sync[1], vsync: ctrl_sync[0]};

endmodule

`default_nettype wire

//--- design/pixel_reconstruct.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_reconstruct #(
  parameter int FRAME_WIDTH  = 1280,
  parameter int FRAME_HEIGHT = 720
) (
  input  wire                     clk_camera,
  input  wire                     recent_reset,
  input  wire video_pkg::cam_bus_t bus_i,
  input  wire                     pclk_rise_i,
  output video_pkg::pixel_beat_t  beat_o,
  output logic                    beat_valid_o
);

  // counts saturate here until the next line or frame
  localparam video_pkg::hcount_t h_last = video_pkg::hcount_t'(FRAME_WIDTH - 1);
  localparam video_pkg::vcount_t v_last = video_pkg::vcount_t'(FRAME_HEIGHT - 1);

  video_pkg::byte_phase_e phase_q;
  video_pkg::cam_byte_t   high_byte_q;
  video_pkg::hcount_t     hcount_q;
  video_pkg::vcount_t     vcount_q;
  logic                   hsync_q;
  logic                   vsync_q;

  logic take_byte;
  logic pixel_done;
  logic hsync_fall;
  logic vsync_rise;

  // a byte is only valid while hsync is high
  assign take_byte  = pclk_rise_i & bus_i.hsync;
  assign pixel_done = take_byte && (phase_q == video_pkg::low_byte);
  assign hsync_fall = hsync_q & ~bus_i.hsync;
  assign vsync_rise = ~vsync_q & bus_i.vsync;

  // ==========================================================
  // byte pairing
  // ==========================================================

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      phase_q <= video_pkg::high_byte;
    end else if (!bus_i.hsync) begin
      // blanking realigns to the first byte of a pixel
      phase_q <= video_pkg::high_byte;
    end else if (pclk_rise_i) begin
      unique case (phase_q)
        video_pkg::high_byte: phase_q <= video_pkg::low_byte;
        video_pkg::low_byte:  phase_q <= video_pkg::high_byte;
      endcase
    end
  end

  // upper half of the pixel waits here for its partner
  always_ff @(posedge clk_camera) begin
    if (take_byte && (phase_q == video_pkg::high_byte)) begin
      high_byte_q <= bus_i.data;
    end
  end

  // pixel goes out one cycle after the low byte strobe
  always_ff @(posedge clk_camera) begin
    if (pixel_done) begin
      beat_o.pixel  <= video_pkg::rgb565_t'({high_byte_q, bus_i.data});
      beat_o.hcount <= hcount_q;
      beat_o.vcount <= vcount_q;
    end
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      beat_valid_o <= 1'b0;
    end else begin
      beat_valid_o <= pixel_done;
    end
  end

  // ==========================================================
  // position counters
  // ==========================================================

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      hsync_q  <= 1'b0;
      vsync_q  <= 1'b0;
      hcount_q <= '0;
      vcount_q <= '0;
    end else begin
      hsync_q <= bus_i.hsync;
      vsync_q <= bus_i.vsync;
      if (vsync_rise) begin
        // new frame
        hcount_q <= '0;
        vcount_q <= '0;
      end else if (hsync_fall) begin
        // end of line, next row
        hcount_q <= '0;
        if (vcount_q != v_last) begin
          vcount_q <= vcount_q + 1'b1;
        end
      end else if (pixel_done && (hcount_q != h_last)) begin
        hcount_q <= hcount_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/green_key_mask.sv
`timescale 1ns/1ps
`default_nettype none

module green_key_mask #(
  parameter logic [7:0] GREEN_LOW  = 8'd0,
  parameter logic [7:0] GREEN_HIGH = 8'd64
) (
  input  wire                        clk_camera,
  input  wire                        recent_reset,
  input  wire video_pkg::pixel_beat_t beat_i,
  input  wire                        beat_valid_i,
  output video_pkg::keyed_beat_t     keyed_o,
  output logic                       keyed_valid_o
);

  // green widened to the 8-bit threshold scale
  logic [7:0] green_wide;

  // borrow-based compares, msb set means the difference went negative
  logic [8:0] low_diff;
  logic [8:0] high_diff;
  logic       in_key;

  // low bits padded with zeros, not replicated
  assign green_wide = {beat_i.pixel.green, 2'b00};

  // green - low, no borrow when green >= low
  assign low_diff  = {1'b0, green_wide} - {1'b0, GREEN_LOW};
  // high - green, no borrow when green <= high
  assign high_diff = {1'b0, GREEN_HIGH} - {1'b0, green_wide};

  // both bounds inclusive
  assign in_key = ~low_diff[8] & ~high_diff[8];

  // payload moves only with a valid beat
  always_ff @(posedge clk_camera) begin
    if (beat_valid_i) begin
      keyed_o.beat <= beat_i;
      keyed_o.mask <= in_key;
    end
  end

  // exactly one cycle behind beat_valid_i
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      keyed_valid_o <= 1'b0;
    end else begin
      keyed_valid_o <= beat_valid_i;
    end
  end

endmodule

`default_nettype wire

//--- design/pixel_stacker.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_stacker #(
  parameter int FRAME_WIDTH  = 1280,
  parameter int FRAME_HEIGHT = 720
) (
  input  wire                        clk_camera,
  input  wire                        recent_reset,
  input  wire video_pkg::keyed_beat_t keyed_i,
  input  wire                        keyed_valid_i,
  output stream_pkg::chunk_t         chunk_o,
  output logic                       chunk_valid_o,
  input  wire                        chunk_ready_i,
  output logic                       overflow_o
);

  localparam int slot_bits = $clog2(stream_pkg::PIXELS_PER_CHUNK);
  localparam logic [slot_bits-1:0] slot_last = slot_bits'(stream_pkg::PIXELS_PER_CHUNK - 1);

  // frame end position, used for the last flag
  localparam video_pkg::hcount_t h_last = video_pkg::hcount_t'(FRAME_WIDTH - 1);
  localparam video_pkg::vcount_t v_last = video_pkg::vcount_t'(FRAME_HEIGHT - 1);

  // ==========================================================
  // fill side
  // ==========================================================

  // next slot to write
  logic [slot_bits-1:0] slot_q;

  // partially built chunk, stale slots get overwritten before use
  stream_pkg::chunk_pixels_t fill_pixels_q;
  stream_pkg::chunk_mask_t   fill_mask_q;

  // fill contents with the incoming pixel dropped into its slot
  stream_pkg::chunk_t chunk_next;

  logic chunk_done;
  logic out_free;
  logic load_out;

  always_comb begin
    chunk_next.pixels         = fill_pixels_q;
    chunk_next.pixels[slot_q] = keyed_i.beat.pixel;
    chunk_next.mask           = fill_mask_q;
    chunk_next.mask[slot_q]   = keyed_i.mask;
    // only meaningful on the eighth pixel
    chunk_next.last = (keyed_i.beat.hcount == h_last) && (keyed_i.beat.vcount == v_last);
  end

  assign chunk_done = keyed_valid_i && (slot_q == slot_last);

  // output register empty, or emptying this cycle
  assign out_free = ~chunk_valid_o | chunk_ready_i;
  assign load_out = chunk_done & out_free;

  always_ff @(posedge clk_camera) begin
    if (keyed_valid_i) begin
      fill_pixels_q <= chunk_next.pixels;
      fill_mask_q   <= chunk_next.mask;
    end
  end

  // ==========================================================
  // output side
  // ==========================================================

  // held chunk only changes on a load
  always_ff @(posedge clk_camera) begin
    if (load_out) begin
      chunk_o <= chunk_next;
    end
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      slot_q        <= '0;
      chunk_valid_o <= 1'b0;
      overflow_o    <= 1'b0;
    end else begin
      // wraps from the last slot back to zero
      if (keyed_valid_i) begin
        slot_q <= slot_q + 1'b1;
      end
      if (load_out) begin
        chunk_valid_o <= 1'b1;
      end else if (chunk_ready_i) begin
        chunk_valid_o <= 1'b0;
      end
      // completed chunk found the output still held, so it is lost
      if (chunk_done && !out_free) begin
        overflow_o <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/camera_mask_stream.sv
`timescale 1ns/1ps
`default_nettype none

module camera_mask_stream #(
  parameter int         FRAME_WIDTH  = 1280,
  parameter int         FRAME_HEIGHT = 720,
  parameter logic [7:0] GREEN_LOW    = 8'd0,
  parameter logic [7:0] GREEN_HIGH   = 8'd64
) (
  input  wire                  clk_camera,
  input  wire                  recent_reset,
  // raw camera pins
  input  wire video_pkg::cam_byte_t camera_d_i,
  input  wire                  cam_pclk_i,
  input  wire                  cam_hsync_i,
  input  wire                  cam_vsync_i,
  // chunk stream out
  output stream_pkg::chunk_t   chunk_o,
  output logic                 chunk_valid_o,
  input  wire                  chunk_ready_i,
  output logic                 overflow_o
);

  // ==========================================================
  // stage wiring
  // ==========================================================

  video_pkg::cam_bus_t    cam_bus;
  logic                   pclk_rise;
  video_pkg::pixel_beat_t beat;
  logic                   beat_valid;
  video_pkg::keyed_beat_t keyed;
  logic                   keyed_valid;

  // pins into the camera clock domain
  camera_input_sync input_sync (
    .clk_camera  (clk_camera),
    .recent_reset(recent_reset),
    .camera_d_i  (camera_d_i),
    .cam_pclk_i  (cam_pclk_i),
    .cam_hsync_i (cam_hsync_i),
    .cam_vsync_i (cam_vsync_i),
    .bus_o       (cam_bus),
    .pclk_rise_o (pclk_rise)
  );

  // byte pairs into rgb565 with position
  pixel_reconstruct #(
    .FRAME_WIDTH (FRAME_WIDTH),
    .FRAME_HEIGHT(FRAME_HEIGHT)
  ) reconstruct (
    .clk_camera  (clk_camera),
    .recent_reset(recent_reset),
    .bus_i       (cam_bus),
    .pclk_rise_i (pclk_rise),
    .beat_o      (beat),
    .beat_valid_o(beat_valid)
  );

  // green-screen key on each pixel
  green_key_mask #(
    .GREEN_LOW (GREEN_LOW),
    .GREEN_HIGH(GREEN_HIGH)
  ) key_mask (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .beat_i       (beat),
    .beat_valid_i (beat_valid),
    .keyed_o      (keyed),
    .keyed_valid_o(keyed_valid)
  );

  // eight keyed pixels per chunk
  pixel_stacker #(
    .FRAME_WIDTH (FRAME_WIDTH),
    .FRAME_HEIGHT(FRAME_HEIGHT)
  ) stacker (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .keyed_i      (keyed),
    .keyed_valid_i(keyed_valid),
    .chunk_o      (chunk_o),
    .chunk_valid_o(chunk_valid_o),
    .chunk_ready_i(chunk_ready_i),
    .overflow_o   (overflow_o)
  );

endmodule

`default_nettype wire

//--- verification/camera_mask_stream_assert.sv
`timescale 1ns/1ps
`default_nettype none

module camera_mask_stream_assert (
  input wire                     clk_camera,
  input wire                     recent_reset,
  input wire                     keyed_valid_i,
  input wire stream_pkg::chunk_t chunk_i,
  input wire                     chunk_valid_i,
  input wire                     chunk_ready_i,
  input wire                     overflow_i
);

  // position of the next keyed pixel inside its chunk, eight per chunk
  logic [2:0] pixel_slot;
  // set once the first eighth pixel has reached the stacker
  logic       first_chunk_seen;
  // keyed pixel that closes a chunk
  logic       eighth_pixel;

  assign eighth_pixel = keyed_valid_i && (pixel_slot == 3'd7);

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      pixel_slot       <= '0;
      first_chunk_seen <= 1'b0;
    end else begin
      if (keyed_valid_i) begin
        pixel_slot <= pixel_slot + 3'd1;
      end
      if (eighth_pixel) begin
        first_chunk_seen <= 1'b1;
      end
    end
  end

  // ==========================================================
  // reset and start-up
  // ==========================================================

  // outputs quiet right after a reset cycle
  reset_quiet: assert property (@(posedge clk_camera)
    recent_reset |=> !chunk_valid_i && !overflow_i)
    else $error("chunk_valid_o or overflow_o high after reset");

  // nothing can come out before eight pixels went in
  quiet_before_first: assert property (@(posedge clk_camera) disable iff (recent_reset)
    !first_chunk_seen |-> !chunk_valid_i && !overflow_i)
    else $error("stacker output active before the first full chunk");

  // ==========================================================
  // back-pressure
  // ==========================================================

  // held chunk frozen until accepted
  hold_stable: assert property (@(posedge clk_camera) disable iff (recent_reset)
    chunk_valid_i && !chunk_ready_i |=> chunk_valid_i && $stable(chunk_i))
    else $error("held chunk changed or dropped valid without ready");

  // sticky until reset
  overflow_sticky: assert property (@(posedge clk_camera) disable iff (recent_reset)
    overflow_i |=> overflow_i)
    else $error("overflow_o fell without reset");

  // only a completion against a held, unaccepted chunk may raise it
  overflow_cause: assert property (@(posedge clk_camera) disable iff (recent_reset)
    $rose(overflow_i) |-> $past(eighth_pixel && chunk_valid_i && !chunk_ready_i))
    else $error("overflow_o rose without a chunk colliding with the held one");

endmodule

bind pixel_stacker camera_mask_stream_assert stacker_checks (
  .clk_camera   (clk_camera),
  .recent_reset (recent_reset),
  .keyed_valid_i(keyed_valid_i),
  .chunk_i      (chunk_o),
  .chunk_valid_i(chunk_valid_o),
  .chunk_ready_i(chunk_ready_i),
  .overflow_i   (overflow_o)
);

`default_nettype wire

//--- verification/tb_camera_mask_stream.sv
`timescale 1ns/1ps
`default_nettype none

module tb_camera_mask_stream;

  // ==========================================================
  // test setup
  // ==========================================================

  localparam int         FRAME_WIDTH  = 16;
  localparam int         FRAME_HEIGHT = 4;
  // thresholds away from 0 so both bounds can be hit from each side
  localparam logic [7:0] GREEN_LOW    = 8'd40;
  localparam logic [7:0] GREEN_HIGH   = 8'd160;
  localparam int         CLK_PERIOD   = 10;
  localparam int         NUM_FRAMES   = 4;
  localparam int         SEED         = 21918;
  // frame where ready stays low across two more completions
  localparam int         OVF_FRAME    = 2;
  // ready comes back once chunk 2 of that frame is surely complete
  localparam int         RELEASE_PIXEL = 26;
  localparam int         PIXELS        = FRAME_WIDTH * FRAME_HEIGHT;
  localparam int         CHUNKS_PER_FRAME = PIXELS / stream_pkg::PIXELS_PER_CHUNK;
  // vsync pulse plus gap after every line, in camera bytes
  localparam int         BLANK_BYTES = 6 + FRAME_HEIGHT * 3;
  // eight camera cycles per byte, doubled for ready stalls
  localparam int         WATCHDOG_NS =
    NUM_FRAMES * (PIXELS * 2 + BLANK_BYTES) * 8 * CLK_PERIOD * 2 + 10000;

  logic                 clk_camera;
  logic                 recent_reset;
  video_pkg::cam_byte_t camera_d_i;
  logic                 cam_pclk_i;
  logic                 cam_hsync_i;
  logic                 cam_vsync_i;
  stream_pkg::chunk_t   chunk_o;
  logic                 chunk_valid_o;
  logic                 chunk_ready_i;
  logic                 overflow_o;

  // reference model state
  stream_pkg::chunk_t exp_q[$];
  stream_pkg::chunk_t fill;
  int                 slot;
  int                 chunk_in_frame;
  int                 accepted;
  logic               hold_ready;

  camera_mask_stream #(
    .FRAME_WIDTH (FRAME_WIDTH),
    .FRAME_HEIGHT(FRAME_HEIGHT),
    .GREEN_LOW   (GREEN_LOW),
    .GREEN_HIGH  (GREEN_HIGH)
  ) UUT (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .camera_d_i   (camera_d_i),
    .cam_pclk_i   (cam_pclk_i),
    .cam_hsync_i  (cam_hsync_i),
    .cam_vsync_i  (cam_vsync_i),
    .chunk_o      (chunk_o),
    .chunk_valid_o(chunk_valid_o),
    .chunk_ready_i(chunk_ready_i),
    .overflow_o   (overflow_o)
  );

  always #(CLK_PERIOD / 2) clk_camera = ~clk_camera;

  task automatic report_mismatch(input string name, input logic [127:0] got,
                                 input logic [127:0] want);
    $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, want);
    $display("Test FAILED");
    $fatal(1, "value check failed");
  endtask

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "run failed");
  endtask

  // green field widened with two zero bits, both bounds inclusive
  function automatic logic key_bit(input logic [15:0] pix);
    logic [7:0] wide;
    wide = {pix[10:5], 2'b00};
    return (wide >= GREEN_LOW) && (wide <= GREEN_HIGH);
  endfunction

  // random pixel, first four of a line pinned around the key bounds
  function automatic logic [15:0] make_pixel(input int h, input int v);
    logic [15:0] pix;
    pix = 16'($urandom);
    if (h < 4) begin
      case ((h + v) % 4)
        0: pix[10:5] = 6'd9;
        1: pix[10:5] = 6'd10;
        2: pix[10:5] = 6'd40;
        default: pix[10:5] = 6'd41;
      endcase
    end
    return pix;
  endfunction

  // one byte per camera pixel clock, data changes on the pclk falling edge
  task automatic drive_cam_byte(input logic [7:0] b, input logic hs, input logic vs);
    @(negedge clk_camera);
    cam_pclk_i  = 1'b0;
    camera_d_i  = b;
    cam_hsync_i = hs;
    cam_vsync_i = vs;
    repeat (4) @(negedge clk_camera);
    cam_pclk_i = 1'b1;
    repeat (3) @(negedge clk_camera);
  endtask

  // junk bytes with hsync low, they must never reach a chunk
  task automatic send_blanking(input int n, input logic vs);
    repeat (n) drive_cam_byte(8'($urandom), 1'b0, vs);
  endtask

  // slots fill lowest first, every eighth chunk closes the frame
  task automatic record_pixel(input int f, input logic [15:0] pix);
    fill.pixels[slot] = pix;
    fill.mask[slot]   = key_bit(pix);
    slot++;
    if (slot == stream_pkg::PIXELS_PER_CHUNK) begin
      fill.last = (chunk_in_frame == CHUNKS_PER_FRAME - 1);
      // chunks 1 and 2 of the stalled frame find chunk 0 still held
      if (!(f == OVF_FRAME && (chunk_in_frame == 1 || chunk_in_frame == 2))) begin
        exp_q.push_back(fill);
      end
      slot = 0;
      chunk_in_frame++;
    end
  endtask

  task automatic send_frame(input int f);
    int          pix_idx;
    logic [15:0] pix;
    pix_idx        = 0;
    chunk_in_frame = 0;
    // vsync pulse resets the counts
    send_blanking(2, 1'b0);
    send_blanking(2, 1'b1);
    send_blanking(2, 1'b0);
    for (int v = 0; v < FRAME_HEIGHT; v++) begin
      for (int h = 0; h < FRAME_WIDTH; h++) begin
        if (f == OVF_FRAME && pix_idx == RELEASE_PIXEL) begin
          hold_ready = 1'b0;
        end
        pix = make_pixel(h, v);
        record_pixel(f, pix);
        drive_cam_byte(pix[15:8], 1'b1, 1'b0);
        drive_cam_byte(pix[7:0], 1'b1, 1'b0);
        pix_idx++;
      end
      // hsync falling edge moves to the next row
      send_blanking(3, 1'b0);
    end
  endtask

  // ==========================================================
  // ready driver and chunk checker
  // ==========================================================

  always @(negedge clk_camera) begin
    stream_pkg::chunk_t want;
    if (hold_ready) begin
      chunk_ready_i = 1'b0;
    end else begin
      chunk_ready_i = ($urandom_range(3) != 0);
    end
    // transfer happens at the next rising edge
    if (!recent_reset && chunk_valid_o && chunk_ready_i) begin
      if (exp_q.size() == 0) begin
        report_failure("DUT offered a chunk while none was expected");
      end else begin
        want = exp_q.pop_front();
        assert (chunk_o.pixels == want.pixels)
          else report_mismatch("chunk_o.pixels", chunk_o.pixels, want.pixels);
        assert (chunk_o.mask == want.mask)
          else report_mismatch("chunk_o.mask", chunk_o.mask, want.mask);
        assert (chunk_o.last == want.last)
          else report_mismatch("chunk_o.last", chunk_o.last, want.last);
        accepted++;
      end
    end
  end

  // ==========================================================
  // main sequence
  // ==========================================================

  initial begin
    void'($urandom(SEED));
    clk_camera     = 1'b0;
    recent_reset   = 1'b1;
    camera_d_i     = '0;
    cam_pclk_i     = 1'b0;
    cam_hsync_i    = 1'b0;
    cam_vsync_i    = 1'b0;
    chunk_ready_i  = 1'b0;
    hold_ready     = 1'b0;
    fill           = '0;
    slot           = 0;
    chunk_in_frame = 0;
    accepted       = 0;
    repeat (5) @(posedge clk_camera);
    @(negedge clk_camera);
    recent_reset = 1'b0;

    for (int f = 0; f < NUM_FRAMES; f++) begin
      // stall frame starts with the output register empty
      while (exp_q.size() != 0) @(negedge clk_camera);
      assert (overflow_o == (f > OVF_FRAME))
        else report_mismatch("overflow_o", overflow_o, f > OVF_FRAME);
      if (f == OVF_FRAME) begin
        hold_ready = 1'b1;
      end
      send_frame(f);
    end

    send_blanking(2, 1'b0);
    while (exp_q.size() != 0) @(negedge clk_camera);
    assert (overflow_o == 1'b1)
      else report_mismatch("overflow_o", overflow_o, 1'b1);
    assert (accepted == NUM_FRAMES * CHUNKS_PER_FRAME - 2)
      else report_mismatch("accepted chunk count", accepted, NUM_FRAMES * CHUNKS_PER_FRAME - 2);
    $display("Test OK");
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns before all frames were checked", WATCHDOG_NS);
    $display("Test FAILED");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

//--- camera_mask_stream.f
design/video_pkg.sv
design/stream_pkg.sv
design/camera_input_sync.sv
design/pixel_reconstruct.sv
design/green_key_mask.sv
design/pixel_stacker.sv
design/camera_mask_stream.sv
verification/camera_mask_stream_assert.sv
verification/tb_camera_mask_stream.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_camera_mask_stream
FILELIST   := camera_mask_stream.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing --assert -Wall --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
